// ==== hw/gem_link_config.svh ====
`ifndef GEM_LINK_CONFIG_SVH
`define GEM_LINK_CONFIG_SVH

// ----------------------------------------
// Widths
// ----------------------------------------
`define GEM_TMR_W         8         // Startup and ready timer counters
`define GEM_WORD_W        56        // Cluster word from the trigger logic
`define GEM_TX_W          16        // Transceiver parallel data

// ----------------------------------------
// Startup timing, in clock_40 cycles
// ----------------------------------------
`define GEM_MGT_RESET_CYC 16        // mgt_reset high after rst or retry
`define GEM_TXRESET_GAP   6         // Lock must be stable this long
`define GEM_DONE_WAIT     20        // Floor between txreset and link up
`define GEM_READY_HOLD    32        // Link up settle time before ready

// ----------------------------------------
// K-codes
// ----------------------------------------
`define GEM_K_BC0         8'h1C     // K28.0
`define GEM_K_RESYNC      8'h3C     // K28.1
`define GEM_K_OVF         8'hFC     // K28.7, more than 8 clusters
`define GEM_K_SEQ0        8'hBC     // K28.5, bunch sequence 0
`define GEM_K_SEQ1        8'hF7     // K23.7
`define GEM_K_SEQ2        8'hFB     // K27.7
`define GEM_K_SEQ3        8'hFD     // K29.7
`define GEM_IDLE_WORD     16'hFFFC  // Sent with isk 01 while link is down

`endif

// ==== hw/gem_link_pkg.sv ====
`default_nettype none

`include "gem_link_config.svh"

package gem_link_pkg;

   // ----------------------------------------
   // Startup FSM
   // ----------------------------------------
   typedef enum logic [2:0] {
      ST_MGT_RESET = 3'd0,   // Transceiver held in reset
      ST_WAIT_LOCK = 3'd1,   // PLL lock, then a guard gap
      ST_TXRESET   = 3'd2,   // Single cycle PCS reset
      ST_WAIT_DONE = 3'd3,   // Reset done plus minimum wait
      ST_LINK_UP   = 3'd4    // Framer may send
   } startup_state_t;

   // ----------------------------------------
   // Frame types
   // ----------------------------------------
   typedef logic [1:0] frame_slot_t;              // 0 is the head slot

   typedef logic [`GEM_WORD_W-1:0] gem_word_t;    // One cluster word

   // Head of a frame, separator in the low byte
   typedef struct packed {
      logic [7:0] data_lo;   // Cluster bits 7:0
      logic [7:0] sep;       // K-code, goes out with isk bit 0 set
   } tx_head_t;

   // Same 16 bits, decoded by slot
   typedef union packed {
      logic [`GEM_TX_W-1:0] raw;   // Payload slices, slots 1 to 3
      tx_head_t             head;  // Slot 0
   } tx_word_u;

endpackage

`default_nettype wire

// ==== hw/gem_link_timer.sv ====
`default_nettype none

`include "gem_link_config.svh"

// Saturating up counter, cleared by clear_i
module gem_link_timer (
   input  wire                   clock_40,
   input  wire                   rst_i,
   input  wire                   clear_i,
   input  wire  [`GEM_TMR_W-1:0] limit_i,
   output logic [`GEM_TMR_W-1:0] count_o,
   output logic                  done_o
);

   // ----------------------------------------
   // Counter
   // ----------------------------------------
   always_ff @(posedge clock_40) begin
      if (rst_i || clear_i) begin
         count_o <= '0;                    // Restart from zero
      end
      else if (count_o < limit_i) begin
         count_o <= count_o + 1'b1;
      end
      else begin
         count_o <= count_o;               // Parked at the limit
      end
   end

   // ----------------------------------------
   // Terminal flag
   // ----------------------------------------

   // High for as long as the count sits on the limit
   assign done_o = (count_o == limit_i);

endmodule

`default_nettype wire

// ==== hw/gem_link_startup.sv ====
`default_nettype none

`include "gem_link_config.svh"

// Transceiver reset sequencer with retry on loss of lock or done
module gem_link_startup (
   input  wire                   clock_40,
   input  wire                   rst_i,
   input  wire                   pll_lock_i,
   input  wire                   tx_done_i,
   input  wire                   tmr_done_i,
   output logic                  tmr_clear_o,
   output logic [`GEM_TMR_W-1:0] tmr_limit_o,
   output logic                  mgt_reset_o,
   output logic                  txreset_o,
   output logic                  link_up_o
);

   import gem_link_pkg::*;

   startup_state_t state_q;   // Current state
   startup_state_t state_d;   // Next state

   // ----------------------------------------
   // State register
   // ----------------------------------------
   always_ff @(posedge clock_40) begin
      if (rst_i) begin
         state_q <= ST_MGT_RESET;
      end
      else begin
         state_q <= state_d;
      end
   end

   // ----------------------------------------
   // Next state
   // ----------------------------------------
   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_MGT_RESET: begin
            if (tmr_done_i) state_d = ST_WAIT_LOCK;
         end
         ST_WAIT_LOCK: begin
            // Timer only runs while lock is present
            if (pll_lock_i && tmr_done_i) state_d = ST_TXRESET;
         end
         ST_TXRESET: begin
            if (!pll_lock_i) state_d = ST_MGT_RESET;   // Retry
            else             state_d = ST_WAIT_DONE;
         end
         ST_WAIT_DONE: begin
            if (!pll_lock_i)                   state_d = ST_MGT_RESET;
            else if (tx_done_i && tmr_done_i)  state_d = ST_LINK_UP;
         end
         ST_LINK_UP: begin
            // Either one dropping restarts the whole sequence
            if (!pll_lock_i || !tx_done_i) state_d = ST_MGT_RESET;
         end
         default: state_d = ST_MGT_RESET;
      endcase
   end

   // ----------------------------------------
   // Timer control
   // ----------------------------------------

   // Fresh count on entry to each state; gap restarts on any lock glitch
   assign tmr_clear_o = (state_d != state_q) ||
                        ((state_q == ST_WAIT_LOCK) && !pll_lock_i);

   // Count runs from 0, so the terminal value is one less than the length
   always_comb begin
      case (state_q)
         ST_MGT_RESET: tmr_limit_o = `GEM_TMR_W'(`GEM_MGT_RESET_CYC - 1);
         ST_WAIT_LOCK: tmr_limit_o = `GEM_TMR_W'(`GEM_TXRESET_GAP - 1);
         ST_WAIT_DONE: tmr_limit_o = `GEM_TMR_W'(`GEM_DONE_WAIT - 1);
         default:      tmr_limit_o = '0;   // Not timed
      endcase
   end

   // ----------------------------------------
   // Outputs
   // ----------------------------------------
   assign mgt_reset_o = (state_q == ST_MGT_RESET);
   assign txreset_o   = (state_q == ST_TXRESET);   // Exactly one cycle
   assign link_up_o   = (state_q == ST_LINK_UP);

endmodule

`default_nettype wire

// ==== hw/gem_link_framer.sv ====
`default_nettype none

`include "gem_link_config.svh"

// Four slot framer: head {data[7:0], sep} then three 16 bit payload slices
module gem_link_framer (
   input  wire                      clock_40,
   input  wire                      rst_i,
   input  wire                      link_up_i,
   input  wire                      word_valid_i,
   output logic                     word_ready_o,
   input  wire gem_link_pkg::gem_word_t gem_data_i,
   input  wire                      overflow_i,
   input  wire                      bc0_i,
   input  wire                      resync_i,
   input  wire  [1:0]               bxn_lsbs_i,
   output gem_link_pkg::tx_word_u   tx_data_o,
   output logic [1:0]               tx_isk_o
);

   import gem_link_pkg::*;

   frame_slot_t            slot_q;      // Slot now on tx_data_o
   logic                   take;        // Handshake completes this edge
   logic [`GEM_WORD_W-9:0] payload_q;   // Upper 48 bits of current word
   logic [7:0]             sep;         // Separator for the offered word
   tx_word_u               tx_next;
   logic [1:0]             isk_next;

   // ----------------------------------------
   // Slot counter and handshake
   // ----------------------------------------

   // Parked at 3 while down, so the first cycle of link up is a ready cycle
   always_ff @(posedge clock_40) begin
      if (rst_i || !link_up_i) begin
         slot_q <= 2'd3;
      end
      else begin
         slot_q <= slot_q + 2'd1;   // Wraps 3 to 0
      end
   end

   assign word_ready_o = link_up_i && (slot_q == 2'd3);  // Head loads next edge
   assign take         = word_ready_o && word_valid_i;

   // ----------------------------------------
   // Separator select
   // ----------------------------------------
   always_comb begin
      if (bc0_i) begin
         sep = `GEM_K_BC0;
      end
      else if (resync_i) begin
         sep = `GEM_K_RESYNC;
      end
      else if (overflow_i) begin
         sep = `GEM_K_OVF;
      end
      else begin
         case (bxn_lsbs_i)   // Bunch sequence follows the TTC counter
            2'd0:    sep = `GEM_K_SEQ0;
            2'd1:    sep = `GEM_K_SEQ1;
            2'd2:    sep = `GEM_K_SEQ2;
            default: sep = `GEM_K_SEQ3;
         endcase
      end
   end

   // ----------------------------------------
   // Payload hold
   // ----------------------------------------
   always_ff @(posedge clock_40) begin
      if (word_ready_o) begin
         // Empty frame carries zeros
         payload_q <= take ? gem_data_i[`GEM_WORD_W-1:8] : '0;
      end
   end

   // ----------------------------------------
   // Next transmit word
   // ----------------------------------------
   always_comb begin
      tx_next.raw = `GEM_IDLE_WORD;   // Idle unless link is up
      isk_next    = 2'b01;
      if (link_up_i) begin
         case (slot_q)   // Current slot, next one goes out
            2'd3: begin
               tx_next.head.data_lo = take ? gem_data_i[7:0] : 8'h00;
               tx_next.head.sep     = take ? sep : `GEM_K_SEQ0;
               isk_next             = 2'b01;   // K-code in low byte
            end
            2'd0: begin
               tx_next.raw = payload_q[15:0];    // Word bits 23:8
               isk_next    = 2'b00;
            end
            2'd1: begin
               tx_next.raw = payload_q[31:16];   // Word bits 39:24
               isk_next    = 2'b00;
            end
            default: begin
               tx_next.raw = payload_q[47:32];   // Word bits 55:40
               isk_next    = 2'b00;
            end
         endcase
      end
   end

   // ----------------------------------------
   // Output register
   // ----------------------------------------
   always_ff @(posedge clock_40) begin
      if (rst_i) begin
         tx_data_o.raw <= `GEM_IDLE_WORD;
         tx_isk_o      <= 2'b01;
      end
      else begin
         tx_data_o <= tx_next;
         tx_isk_o  <= isk_next;
      end
   end

endmodule

`default_nettype wire

// ==== hw/gem_link_top.sv ====
`default_nettype none

`include "gem_link_config.svh"

// Single optical link, startup sequencer plus framer on clock_40
module gem_link_top (
   input  wire                      clock_40,
   input  wire                      rst_i,
   input  wire                      pll_lock_i,
   input  wire                      tx_done_i,
   input  wire                      force_not_ready_i,
   input  wire                      word_valid_i,
   input  wire gem_link_pkg::gem_word_t gem_data_i,
   input  wire                      overflow_i,
   input  wire                      bc0_i,
   input  wire                      resync_i,
   input  wire  [1:0]               bxn_lsbs_i,
   output wire                      word_ready_o,
   output wire gem_link_pkg::tx_word_u tx_data_o,
   output wire  [1:0]               tx_isk_o,
   output wire                      mgt_reset_o,
   output wire                      txreset_o,
   output wire                      link_up_o,
   output wire                      link_ready_o
);

   wire                  tmr_clear;     // Startup timer restart
   wire [`GEM_TMR_W-1:0] tmr_limit;     // Per state terminal count
   wire                  tmr_done;
   wire                  ready_clear;   // Ready hold restart

   // ----------------------------------------
   // Startup sequencer
   // ----------------------------------------
   gem_link_startup u_startup (
      .clock_40    (clock_40),
      .rst_i       (rst_i),
      .pll_lock_i  (pll_lock_i),
      .tx_done_i   (tx_done_i),
      .tmr_done_i  (tmr_done),
      .tmr_clear_o (tmr_clear),
      .tmr_limit_o (tmr_limit),
      .mgt_reset_o (mgt_reset_o),
      .txreset_o   (txreset_o),
      .link_up_o   (link_up_o)
   );

   gem_link_timer u_startup_timer (
      .clock_40 (clock_40),
      .rst_i    (rst_i),
      .clear_i  (tmr_clear),
      .limit_i  (tmr_limit),
      .count_o  (),
      .done_o   (tmr_done)
   );

   // ----------------------------------------
   // Ready hold
   // ----------------------------------------
   assign ready_clear = !link_up_o || force_not_ready_i;

   gem_link_timer u_ready_timer (
      .clock_40 (clock_40),
      .rst_i    (rst_i),
      .clear_i  (ready_clear),
      .limit_i  (`GEM_TMR_W'(`GEM_READY_HOLD)),
      .count_o  (),
      .done_o   (link_ready_o)   // Saturated count means ready
   );

   // ----------------------------------------
   // Framer
   // ----------------------------------------
   gem_link_framer u_framer (
      .clock_40     (clock_40),
      .rst_i        (rst_i),
      .link_up_i    (link_up_o),
      .word_valid_i (word_valid_i),
      .word_ready_o (word_ready_o),
      .gem_data_i   (gem_data_i),
      .overflow_i   (overflow_i),
      .bc0_i        (bc0_i),
      .resync_i     (resync_i),
      .bxn_lsbs_i   (bxn_lsbs_i),
      .tx_data_o    (tx_data_o),
      .tx_isk_o     (tx_isk_o)
   );

endmodule

`default_nettype wire

// ==== bench/tb_gem_link_table.svh ====
`ifndef TB_GEM_LINK_TABLE_SVH
`define TB_GEM_LINK_TABLE_SVH

// Each row holds valid gaps, random flag, data, overflow, bc0, resync, bxn_lsbs
// and the expected separator; GAP_RND draws 0 to 2 gaps from $urandom

localparam logic [3:0] GAP_RND   = 4'hF;
localparam int         NUM_ROWS  = 16;
localparam int         RETRY_ROW = 10;   // Lock drops before this row

typedef struct packed {
   logic [3:0] gap;      // Ready cycles left empty before the word
   logic       rnd;      // Payload from $urandom instead of data
   gem_word_t  data;
   logic       ovf;
   logic       bc0;
   logic       resync;
   logic [1:0] bxn;
   logic [7:0] sep;      // K-code by bc0, resync, overflow, then bxn
} row_t;

localparam row_t ROWS [NUM_ROWS] = '{
   // Bunch sequence codes, back to back
   '{4'd0,   1'b0, 56'h11_2233_4455_6677, 1'b0, 1'b0, 1'b0, 2'd0, `GEM_K_SEQ0},
   '{4'd0,   1'b0, 56'hA1_A2A3_A4A5_A6A7, 1'b0, 1'b0, 1'b0, 2'd1, `GEM_K_SEQ1},
   '{4'd0,   1'b0, 56'h0F_1E2D_3C4B_5A69, 1'b0, 1'b0, 1'b0, 2'd2, `GEM_K_SEQ2},
   '{4'd0,   1'b0, 56'hFE_DCBA_9876_5432, 1'b0, 1'b0, 1'b0, 2'd3, `GEM_K_SEQ3},
   // Priority between the flags
   '{4'd0,   1'b0, 56'h80_0000_0000_0001, 1'b1, 1'b1, 1'b1, 2'd2, `GEM_K_BC0},
   '{4'd1,   1'b0, 56'h55_AA55_AA55_AA55, 1'b1, 1'b0, 1'b1, 2'd3, `GEM_K_RESYNC},
   '{4'd0,   1'b0, 56'h01_0203_0405_0607, 1'b1, 1'b0, 1'b0, 2'd1, `GEM_K_OVF},
   '{4'd2,   1'b0, 56'hC3_3CC3_3CC3_3CC3, 1'b0, 1'b1, 1'b0, 2'd0, `GEM_K_BC0},
   '{GAP_RND, 1'b1, 56'h0,               1'b0, 1'b0, 1'b0, 2'd1, `GEM_K_SEQ1},
   '{4'd0,   1'b1, 56'h0,                1'b0, 1'b0, 1'b1, 2'd0, `GEM_K_RESYNC},
   // After the retry
   '{4'd0,   1'b0, 56'h7E_E7DB_BD99_6600, 1'b0, 1'b0, 1'b0, 2'd2, `GEM_K_SEQ2},
   '{4'd3,   1'b1, 56'h0,                1'b1, 1'b0, 1'b0, 2'd3, `GEM_K_OVF},
   '{GAP_RND, 1'b1, 56'h0,               1'b0, 1'b1, 1'b1, 2'd1, `GEM_K_BC0},
   '{4'd0,   1'b0, 56'hFF_FFFF_FFFF_FFFF, 1'b0, 1'b0, 1'b0, 2'd3, `GEM_K_SEQ3},
   // Zero payload, told apart from the empty frame before it by its separator
   '{4'd1,   1'b0, 56'h00_0000_0000_0000, 1'b0, 1'b0, 1'b0, 2'd1, `GEM_K_SEQ1},
   '{4'd0,   1'b1, 56'h0,                1'b1, 1'b1, 1'b0, 2'd2, `GEM_K_BC0}
};

`endif

// ==== bench/tb_gem_link.sv ====
`default_nettype none

`include "gem_link_config.svh"

module tb_gem_link;

   import gem_link_pkg::*;

   `include "tb_gem_link_table.svh"

   localparam int LOCK_DELAY  = 10;   // PLL still locking after reset
   localparam int DONE_DELAY  = 4;    // txreset to reset done
   localparam int STARTUP_CYC = `GEM_MGT_RESET_CYC + `GEM_TXRESET_GAP + 1 + `GEM_DONE_WAIT;
   // Two startups, three hold periods, at most four frames per row
   localparam int TIMEOUT_CYC = 2 * (STARTUP_CYC + LOCK_DELAY) + 3 * `GEM_READY_HOLD
                                + 16 * NUM_ROWS + 200;

   logic        clock_40;
   logic        rst_i;
   logic        pll_lock_i;
   logic        tx_done_i;
   logic        force_not_ready_i;
   logic        word_valid_i;
   gem_word_t   gem_data_i;
   logic        overflow_i;
   logic        bc0_i;
   logic        resync_i;
   logic [1:0]  bxn_lsbs_i;
   logic        word_ready_o;
   tx_word_u    tx_data_o;
   logic [1:0]  tx_isk_o;
   logic        mgt_reset_o;
   logic        txreset_o;
   logic        link_up_o;
   logic        link_ready_o;

   gem_word_t   data_q [$];         // Offered words, oldest first
   logic [7:0]  sep_q [$];          // Their expected separators
   gem_word_t   m_frame;            // Word in the frame on the wire
   frame_slot_t m_slot;             // Slot shown this cycle
   tx_word_u    exp_word;
   logic [1:0]  exp_isk;
   logic        exp_head;           // Slot 0 goes through the head view
   logic        exp_ready;
   logic        mon_en;
   int          accepted;
   int          txreset_cycles;
   int          cycle_count = 0;

   gem_link_top u_dut (
      .clock_40          (clock_40),
      .rst_i             (rst_i),
      .pll_lock_i        (pll_lock_i),
      .tx_done_i         (tx_done_i),
      .force_not_ready_i (force_not_ready_i),
      .word_valid_i      (word_valid_i),
      .gem_data_i        (gem_data_i),
      .overflow_i        (overflow_i),
      .bc0_i             (bc0_i),
      .resync_i          (resync_i),
      .bxn_lsbs_i        (bxn_lsbs_i),
      .word_ready_o      (word_ready_o),
      .tx_data_o         (tx_data_o),
      .tx_isk_o          (tx_isk_o),
      .mgt_reset_o       (mgt_reset_o),
      .txreset_o         (txreset_o),
      .link_up_o         (link_up_o),
      .link_ready_o      (link_ready_o)
   );

   initial begin
      clock_40 = 1'b0;
      forever #2 clock_40 = ~clock_40;   // Period 4
   end

   // ----------------------------------------
   // Compare tasks
   // ----------------------------------------
   task automatic stop_with_failure(input string msg);
      $display("%s", msg);
      $display(">>> FAIL");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_word(input string name, input tx_word_u act, input tx_word_u exp,
                             input logic head_view);
      if (head_view) begin
         if (act.head.sep !== exp.head.sep) begin
            stop_with_failure($sformatf("error at %0t: %s.head.sep expected %h, got %h",
                                        $time, name, exp.head.sep, act.head.sep));
         end
         if (act.head.data_lo !== exp.head.data_lo) begin
            stop_with_failure($sformatf("error at %0t: %s.head.data_lo expected %h, got %h",
                                        $time, name, exp.head.data_lo, act.head.data_lo));
         end
      end
      else if (act.raw !== exp.raw) begin
         stop_with_failure($sformatf("error at %0t: %s.raw expected %h, got %h",
                                     $time, name, exp.raw, act.raw));
      end
   endtask

   task automatic check_isk(input logic [1:0] act, input logic [1:0] exp);
      if (act !== exp) begin
         stop_with_failure($sformatf("error at %0t: tx_isk_o expected %b, got %b",
                                     $time, exp, act));
      end
   endtask

   task automatic check_bit(input string name, input logic act, input logic exp);
      if (act !== exp) begin
         stop_with_failure($sformatf("error at %0t: %s expected %b, got %b",
                                     $time, name, exp, act));
      end
   endtask

   task automatic check_count(input string name, input int act, input int exp);
      if (act != exp) begin
         stop_with_failure($sformatf("error at %0t: %s expected %0d, got %0d",
                                     $time, name, exp, act));
      end
   endtask

   // ----------------------------------------
   // Stimulus helpers
   // ----------------------------------------
   task automatic next_drive_point();
      @(posedge clock_40);
      #1;                                  // Inputs move clear of the edge
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) next_drive_point();
   endtask

   // Offers one table row through the handshake, starting at a drive point
   task automatic send_row(input int idx);
      int          gaps;
      logic [63:0] rnd_bits;
      logic        taken;
      gaps = (ROWS[idx].gap == GAP_RND) ? int'($urandom % 3) : int'(ROWS[idx].gap);
      word_valid_i = 1'b0;
      while (gaps > 0) begin
         @(negedge clock_40);
         if (word_ready_o) begin
            gaps = gaps - 1;               // That frame goes out empty
         end
         next_drive_point();
      end
      if (ROWS[idx].rnd) begin
         rnd_bits   = {$urandom, $urandom};
         gem_data_i = rnd_bits[55:0];
      end
      else begin
         gem_data_i = ROWS[idx].data;
      end
      overflow_i   = ROWS[idx].ovf;
      bc0_i        = ROWS[idx].bc0;
      resync_i     = ROWS[idx].resync;
      bxn_lsbs_i   = ROWS[idx].bxn;
      word_valid_i = 1'b1;
      data_q.push_back(gem_data_i);
      sep_q.push_back(ROWS[idx].sep);
      do begin
         @(negedge clock_40);
         taken = word_ready_o;             // Held until ready
         next_drive_point();
      end while (!taken);
   endtask

   // Plays the transceiver side of startup; ends on the first link up sample
   task automatic bring_link_up();
      wait_cycles(LOCK_DELAY);
      check_count("txreset_o cycles before lock", txreset_cycles, 0);
      pll_lock_i = 1'b1;
      do @(negedge clock_40); while (!txreset_o);
      wait_cycles(DONE_DELAY);
      tx_done_i = 1'b1;
      do @(negedge clock_40); while (!link_up_o);
      check_count("txreset_o cycles", txreset_cycles, 1);   // One pulse, one cycle
      check_bit("mgt_reset_o", mgt_reset_o, 1'b0);
   endtask

   // Call on the sample where the ready counter has just restarted
   task automatic check_ready_hold();
      check_bit("link_ready_o", link_ready_o, 1'b0);
      repeat (`GEM_READY_HOLD - 1) @(negedge clock_40);
      check_bit("link_ready_o", link_ready_o, 1'b0);   // One short
      @(negedge clock_40);
      check_bit("link_ready_o", link_ready_o, 1'b1);
   endtask

   task automatic drop_lock_and_recover();
      tx_word_u idle_word;
      idle_word.raw  = `GEM_IDLE_WORD;
      pll_lock_i     = 1'b0;               // Done still high, only lock loss retries
      txreset_cycles = 0;
      @(negedge clock_40);                 // Before the edge
      @(negedge clock_40);
      check_bit("link_up_o", link_up_o, 1'b0);
      check_bit("mgt_reset_o", mgt_reset_o, 1'b1);
      @(negedge clock_40);
      check_word("tx_data_o", tx_data_o, idle_word, 1'b0);
      check_isk(tx_isk_o, 2'b01);
      check_bit("link_ready_o", link_ready_o, 1'b0);
      next_drive_point();
      tx_done_i = 1'b0;                    // Transceiver back in reset
      bring_link_up();
   endtask

   // ----------------------------------------
   // Output model, checked mid cycle
   // ----------------------------------------
   always @(negedge clock_40) begin
      if (mon_en) begin
         check_word("tx_data_o", tx_data_o, exp_word, exp_head);
         check_isk(tx_isk_o, exp_isk);
         exp_ready = link_up_o && (m_slot == 2'd3);   // Slot 3 or first cycle up
         check_bit("word_ready_o", word_ready_o, exp_ready);
         exp_head = 1'b0;
         if (!link_up_o) begin
            exp_word.raw = `GEM_IDLE_WORD;
            exp_isk      = 2'b01;
            m_slot       = 2'd3;
         end
         else begin
            case (m_slot)
               2'd3: begin
                  if (!word_valid_i) begin
                     m_frame           = '0;          // Empty frame
                     exp_word.head.sep = `GEM_K_SEQ0;
                  end
                  else if (data_q.size() == 0) begin
                     stop_with_failure("handshake completed with no word offered");
                  end
                  else begin
                     m_frame           = data_q.pop_front();
                     exp_word.head.sep = sep_q.pop_front();
                     accepted          = accepted + 1;
                  end
                  exp_word.head.data_lo = m_frame[7:0];
                  exp_isk  = 2'b01;
                  exp_head = 1'b1;
               end
               2'd0: begin
                  exp_word.raw = m_frame[23:8];
                  exp_isk      = 2'b00;
               end
               2'd1: begin
                  exp_word.raw = m_frame[39:24];
                  exp_isk      = 2'b00;
               end
               default: begin
                  exp_word.raw = m_frame[55:40];
                  exp_isk      = 2'b00;
               end
            endcase
            m_slot = m_slot + 2'd1;
         end
      end
   end

   always @(negedge clock_40) begin
      if (txreset_o) begin
         txreset_cycles = txreset_cycles + 1;
      end
   end

   always @(posedge clock_40) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYC) begin
         stop_with_failure($sformatf("timeout after %0d cycles, link or handshake stuck",
                                     TIMEOUT_CYC));
      end
   end

   // ----------------------------------------
   // Test sequence
   // ----------------------------------------
   initial begin
      rst_i             = 1'b1;
      pll_lock_i        = 1'b0;
      tx_done_i         = 1'b0;
      force_not_ready_i = 1'b0;
      word_valid_i      = 1'b0;
      gem_data_i        = '0;
      overflow_i        = 1'b0;
      bc0_i             = 1'b0;
      resync_i          = 1'b0;
      bxn_lsbs_i        = 2'd0;
      mon_en            = 1'b0;
      accepted          = 0;
      txreset_cycles    = 0;
      exp_word.raw      = `GEM_IDLE_WORD;
      exp_isk           = 2'b01;
      exp_head          = 1'b0;
      m_slot            = 2'd3;
      m_frame           = '0;
      void'($urandom(32'hffe2cb41));
      repeat (3) @(posedge clock_40);
      #1;
      rst_i  = 1'b0;
      mon_en = 1'b1;
      @(negedge clock_40);
      check_bit("mgt_reset_o", mgt_reset_o, 1'b1);
      check_bit("txreset_o", txreset_o, 1'b0);
      check_bit("link_up_o", link_up_o, 1'b0);
      check_bit("link_ready_o", link_ready_o, 1'b0);
      next_drive_point();
      bring_link_up();
      check_ready_hold();
      next_drive_point();
      force_not_ready_i = 1'b1;            // One cycle only
      next_drive_point();
      force_not_ready_i = 1'b0;
      @(negedge clock_40);
      check_ready_hold();
      next_drive_point();
      for (int i = 0; i < RETRY_ROW; i++) begin
         send_row(i);
      end
      word_valid_i = 1'b0;
      wait_cycles(8);                      // Last frame drains
      drop_lock_and_recover();
      next_drive_point();
      for (int i = RETRY_ROW; i < NUM_ROWS; i++) begin
         send_row(i);
      end
      word_valid_i = 1'b0;
      wait_cycles(8);
      if (data_q.size() == 0 && accepted == NUM_ROWS) begin
         $display(">>> PASS");
         $finish;
      end
      else begin
         stop_with_failure($sformatf("%0d of %0d table words framed, %0d still queued",
                                     accepted, NUM_ROWS, data_q.size()));
      end
   end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+hw
+incdir+bench
hw/gem_link_pkg.sv
hw/gem_link_timer.sv
hw/gem_link_startup.sv
hw/gem_link_framer.sv
hw/gem_link_top.sv
bench/tb_gem_link.sv

// ==== Makefile ====
# Verilator build and run of the single link framer testbench

VERILATOR ?= verilator
TOP       ?= tb_gem_link
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard hw/*.svh bench/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source, a header or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Result comes from the log, not from the exit status
run: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q '>>> PASS' $(LOG); then echo "simulation ended without a result"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
